/* sources.f */
x86_core_pkg.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
pipeline_top.sv
pipeline_properties.sv
tb_pipeline.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pipeline \
   -f sources.f -o tb_pipeline_sim || exit 1
out=$(./obj_dir/tb_pipeline_sim)
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1

/* tb_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline;
   import x86_core_pkg::*;

   localparam int cnt_w = 16;

   // Opcode mix for the random stream with two bytes outside the subset
   localparam logic [7:0] rand_ops [16] = '{
      8'h01, 8'h09, 8'h21, 8'h29, 8'h31, 8'h89, 8'hB8, 8'h01,
      8'h29, 8'h31, 8'h89, 8'hB8, 8'hB8, 8'h21, 8'h90, 8'h0F
   };

   logic             clk, rst, instr_valid, instr_ready, halted;
   instr_t           instr;
   reg_id_t          reg_sel;
   data_t            reg_data, eflags;
   logic [cnt_w-1:0] retired_count;

   // Reference model state
   data_t            m_regs [num_gprs];
   data_t            m_flags;
   logic [cnt_w-1:0] m_count;

   int errors, passes, fails, seed;

   pipeline_top #(.retire_count_width(cnt_w)) dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(input logic [cnt_w-1:0] got, input logic [cnt_w-1:0] exp);
      if (got !== exp) begin
         $display("Fail retired_count: got 0x%04h expected 0x%04h", got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // Register to register form with rm as the destination
   function automatic instr_t encode(input opcode_t op, input reg_id_t dst, input reg_id_t src,
                                     input data_t imm);
      return {op, 2'b11, src, dst, imm};
   endfunction

   // One retirement of the reference model
   function automatic void model_exec(input instr_t w);
      reg_id_t dst;
      data_t   a, b, r;
      longint  s;
      logic    wr, fl, cf, of;
      dst = w[34:32];
      a   = m_regs[dst];
      b   = m_regs[w[37:35]];
      {wr, fl, cf} = 3'b110;
      s = 0;
      m_count++;
      case (opcode_t'(w[47:40]))
         op_add: begin
            r  = a + b;
            cf = ({32'h0, a} + {32'h0, b}) > 64'hFFFF_FFFF;
            s  = longint'($signed(a)) + longint'($signed(b));
         end
         op_sub: begin
            r  = a - b;
            cf = a < b;
            s  = longint'($signed(a)) - longint'($signed(b));
         end
         op_and:     r = a & b;
         op_or:      r = a | b;
         op_xor:     r = a ^ b;
         op_mov:     {r, fl} = {b, 1'b0};
         op_mov_imm: {r, fl} = {w[31:0], 1'b0};
         default:    {r, wr, fl} = {32'h0, 2'b00};
      endcase
      // Exact result outside the signed 32-bit range
      of = (s > 64'sd2147483647) || (s < -64'sd2147483648);
      if (wr) begin
         m_regs[dst] = r;
      end
      if (fl) begin
         m_flags[cf_bit] = cf;
         m_flags[zf_bit] = (r == 32'h0);
         m_flags[sf_bit] = r[31];
         m_flags[of_bit] = of;
      end
   endfunction

   task automatic issue(input instr_t w);
      int t;
      t = 0;
      instr_valid = 1'b1;
      instr = w;
      while (!instr_ready && t < 20) begin
         @(posedge clk);
         #1;
         t++;
      end
      if (instr_ready) begin
         model_exec(w);
      end else begin
         $display("Timeout: instr_ready stayed low");
         errors++;
      end
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
   endtask

   task automatic drain();
      int t;
      t = 0;
      while (retired_count !== m_count && t < 50) begin
         @(posedge clk);
         #1;
         t++;
      end
      if (retired_count !== m_count) begin
         $display("Timeout: pipeline did not drain");
         errors++;
      end
   endtask

   // One register per cycle, sampled mid-cycle
   task automatic check_state();
      for (int i = 0; i < num_gprs; i++) begin
         reg_sel = reg_id_t'(i);
         #1;
         check_data($sformatf("gpr%0d", i), reg_data, m_regs[i]);
         @(posedge clk);
         #1;
      end
      check_data("eflags", eflags, m_flags);
      check_count(retired_count, m_count);
   endtask

   task automatic report_test(input string name, input int e0);
      if (errors == e0) begin
         $display("Test %s: ok", name);
         passes++;
      end else begin
         $display("Test %s: %0d errors", name, errors - e0);
         fails++;
      end
   endtask

   task automatic reset_test();
      int e0;
      e0 = errors;
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < num_gprs; i++) begin
         m_regs[i] = 32'h0;
      end
      m_flags = 32'h2;
      m_count = '0;
      check_bit("halted", halted, 1'b0);
      check_bit("instr_ready", instr_ready, 1'b1);
      check_state();
      report_test("reset", e0);
   endtask

   task automatic mov_test();
      int e0;
      e0 = errors;
      for (int i = 0; i < num_gprs; i++) begin
         issue(encode(op_mov_imm, reg_id_t'(i), 3'd0, 32'h1010_0101 * (i + 1)));
      end
      issue(encode(op_mov, 3'd5, 3'd2, '0));
      issue(encode(op_mov, 3'd0, 3'd7, '0));
      // Readback latency is fixed at three edges
      repeat (3) @(posedge clk);
      #1;
      check_data("eflags", eflags, 32'h2);
      check_state();
      report_test("mov", e0);
   endtask

   task automatic bypass_test();
      int e0;
      e0 = errors;
      issue(encode(op_add, 3'd1, 3'd0, '0));
      issue(encode(op_sub, 3'd2, 3'd1, '0));
      issue(encode(op_xor, 3'd1, 3'd2, '0));
      issue(encode(op_or, 3'd3, 3'd1, '0));
      issue(encode(op_and, 3'd3, 3'd6, '0));
      issue(encode(op_add, 3'd4, 3'd3, '0));
      issue(encode(op_mov, 3'd4, 3'd4, '0));
      drain();
      check_state();
      report_test("bypass", e0);
   endtask

   task automatic flag_step(input instr_t w, input data_t exp);
      issue(w);
      drain();
      check_data("eflags", eflags, exp);
   endtask

   task automatic flags_test();
      int e0;
      e0 = errors;
      issue(encode(op_mov_imm, 3'd0, 3'd0, 32'hFFFF_FFFF));
      issue(encode(op_mov_imm, 3'd1, 3'd0, 32'h1));
      issue(encode(op_mov_imm, 3'd2, 3'd0, 32'h7FFF_FFFF));
      issue(encode(op_mov_imm, 3'd3, 3'd0, 32'h0));
      flag_step(encode(op_add, 3'd0, 3'd1, '0), 32'h0000_0043);
      flag_step(encode(op_add, 3'd2, 3'd1, '0), 32'h0000_0882);
      flag_step(encode(op_sub, 3'd3, 3'd1, '0), 32'h0000_0083);
      // Logic op after a borrow
      flag_step(encode(op_xor, 3'd3, 3'd2, '0), 32'h0000_0002);
      check_state();
      report_test("flags", e0);
   endtask

   task automatic random_test();
      int          e0;
      logic [31:0] r;
      data_t       imm;
      e0 = errors;
      for (int n = 0; n < 200; n++) begin
         r   = $random(seed);
         imm = $random(seed);
         issue({rand_ops[r[3:0]], r[15:8], imm});
      end
      drain();
      check_state();
      report_test("random", e0);
   endtask

   task automatic halt_test();
      int e0;
      int t;
      e0 = errors;
      issue(encode(op_hlt, 3'd0, 3'd0, '0));
      check_bit("instr_ready", instr_ready, 1'b0);
      // Offer one more instruction at the closed input
      instr_valid = 1'b1;
      instr = encode(op_mov_imm, 3'd0, 3'd0, 32'hDEAD_BEEF);
      for (t = 0; t < 10; t++) begin
         if (instr_ready) begin
            $display("Instruction after HLT was accepted");
            errors++;
         end
         @(posedge clk);
         #1;
      end
      t = 0;
      while (halted !== 1'b1 && t < 20) begin
         @(posedge clk);
         #1;
         t++;
      end
      instr_valid = 1'b0;
      check_bit("halted", halted, 1'b1);
      check_state();
      report_test("halt", e0);
   endtask

   initial begin
      rst = 1'b1;
      instr_valid = 1'b0;
      instr = '0;
      reg_sel = '0;
      errors = 0;
      passes = 0;
      fails = 0;
      seed = 32'ha0cc5aae;
      reset_test();
      mov_test();
      bypass_test();
      flags_test();
      random_test();
      halt_test();
      $display("Tests passed %0d, failed %0d, errors %0d", passes, fails, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* pipeline_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_properties #(
   parameter int retire_count_width = 16
) (
   input wire                           clk,
   input wire                           rst,
   input wire                           instr_ready,
   input wire                           halted,
   input wire [retire_count_width-1:0]  retired_count
);

   // A halted core takes no more instructions
   ready_low_when_halted: assert property (
      @(posedge clk) disable iff (rst) halted |-> !instr_ready
   ) else $error("instr_ready high while halted");

   // Nothing retires after the HLT
   count_frozen_when_halted: assert property (
      @(posedge clk) disable iff (rst) halted |=> $stable(retired_count)
   ) else $error("retired_count changed while halted");

   not_halted_after_reset: assert property (
      @(posedge clk) rst |=> !halted
   ) else $error("halted high after reset");

endmodule

bind pipeline_top pipeline_properties #(
   .retire_count_width (retire_count_width)
) u_properties (
   .clk           (clk),
   .rst           (rst),
   .instr_ready   (instr_ready),
   .halted        (halted),
   .retired_count (retired_count)
);

`default_nettype wire

/* pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeline_top
   import x86_core_pkg::*;
#(
   parameter int retire_count_width = 16
) (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            instr_valid,
   input  wire instr_t                    instr,
   output logic                           instr_ready,
   input  wire reg_id_t                   reg_sel,
   output data_t                          reg_data,
   output data_t                          eflags,
   output logic [retire_count_width-1:0]  retired_count,
   output logic                           halted
);

   // Decode to execute
   logic    dec_valid;
   alu_op_t dec_alu_op;
   reg_id_t dec_dst;
   reg_id_t dec_src_a;
   reg_id_t dec_src_b;
   logic    dec_use_imm;
   data_t   dec_imm;
   logic    dec_writes_reg;
   logic    dec_writes_flags;
   logic    dec_halt;

   // Execute to writeback
   logic    res_valid;
   reg_id_t res_dst;
   data_t   res_data;
   logic    res_writes_reg;
   data_t   res_flags;
   logic    res_writes_flags;
   logic    res_halt;

   // Register file read port
   reg_id_t rf_rd_a;
   reg_id_t rf_rd_b;
   data_t   rf_data_a;
   data_t   rf_data_b;

   decode_stage u_decode (
      .clk              (clk),
      .rst              (rst),
      .instr_valid      (instr_valid),
      .instr            (instr),
      .instr_ready      (instr_ready),
      .halted           (halted),
      .dec_valid        (dec_valid),
      .dec_alu_op       (dec_alu_op),
      .dec_dst          (dec_dst),
      .dec_src_a        (dec_src_a),
      .dec_src_b        (dec_src_b),
      .dec_use_imm      (dec_use_imm),
      .dec_imm          (dec_imm),
      .dec_writes_reg   (dec_writes_reg),
      .dec_writes_flags (dec_writes_flags),
      .dec_halt         (dec_halt)
   );

   execute_stage u_execute (
      .clk              (clk),
      .rst              (rst),
      .dec_valid        (dec_valid),
      .dec_alu_op       (dec_alu_op),
      .dec_dst          (dec_dst),
      .dec_src_a        (dec_src_a),
      .dec_src_b        (dec_src_b),
      .dec_use_imm      (dec_use_imm),
      .dec_imm          (dec_imm),
      .dec_writes_reg   (dec_writes_reg),
      .dec_writes_flags (dec_writes_flags),
      .dec_halt         (dec_halt),
      .rf_rd_a          (rf_rd_a),
      .rf_rd_b          (rf_rd_b),
      .rf_data_a        (rf_data_a),
      .rf_data_b        (rf_data_b),
      .res_valid        (res_valid),
      .res_dst          (res_dst),
      .res_data         (res_data),
      .res_writes_reg   (res_writes_reg),
      .res_flags        (res_flags),
      .res_writes_flags (res_writes_flags),
      .res_halt         (res_halt)
   );

   writeback_stage #(
      .retire_count_width (retire_count_width)
   ) u_writeback (
      .clk              (clk),
      .rst              (rst),
      .res_valid        (res_valid),
      .res_dst          (res_dst),
      .res_data         (res_data),
      .res_writes_reg   (res_writes_reg),
      .res_flags        (res_flags),
      .res_writes_flags (res_writes_flags),
      .res_halt         (res_halt),
      .rf_rd_a          (rf_rd_a),
      .rf_rd_b          (rf_rd_b),
      .rf_data_a        (rf_data_a),
      .rf_data_b        (rf_data_b),
      .reg_sel          (reg_sel),
      .reg_data         (reg_data),
      .eflags           (eflags),
      .retired_count    (retired_count),
      .halted           (halted)
   );

endmodule

`default_nettype wire

/* writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
   import x86_core_pkg::*;
#(
   parameter int retire_count_width = 16
) (
   input  wire                            clk,
   input  wire                            rst,
   input  wire                            res_valid,
   input  wire reg_id_t                   res_dst,
   input  wire data_t                     res_data,
   input  wire                            res_writes_reg,
   input  wire data_t                     res_flags,
   input  wire                            res_writes_flags,
   input  wire                            res_halt,
   input  wire reg_id_t                   rf_rd_a,
   input  wire reg_id_t                   rf_rd_b,
   output data_t                          rf_data_a,
   output data_t                          rf_data_b,
   input  wire reg_id_t                   reg_sel,
   output data_t                          reg_data,
   output data_t                          eflags,
   output logic [retire_count_width-1:0]  retired_count,
   output logic                           halted
);

   data_t gprs [num_gprs];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_gprs; i++) begin
            gprs[i] <= '0;
         end
         eflags        <= eflags_reset;
         retired_count <= '0;
         halted        <= 1'b0;
      end else if (res_valid) begin
         if (res_writes_reg) begin
            gprs[res_dst] <= res_data;
         end
         // Untracked EFLAGS bits keep their value
         if (res_writes_flags) begin
            eflags[cf_bit] <= res_flags[cf_bit];
            eflags[zf_bit] <= res_flags[zf_bit];
            eflags[sf_bit] <= res_flags[sf_bit];
            eflags[of_bit] <= res_flags[of_bit];
         end
         // No-ops and HLT count as retired too
         retired_count <= retired_count + 1'b1;
         if (res_halt) begin
            halted <= 1'b1;
         end
      end
   end

   // Operand reads for execute
   assign rf_data_a = gprs[rf_rd_a];
   assign rf_data_b = gprs[rf_rd_b];

   // Readback port
   assign reg_data = gprs[reg_sel];

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
   import x86_core_pkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire           dec_valid,
   input  wire alu_op_t  dec_alu_op,
   input  wire reg_id_t  dec_dst,
   input  wire reg_id_t  dec_src_a,
   input  wire reg_id_t  dec_src_b,
   input  wire           dec_use_imm,
   input  wire data_t    dec_imm,
   input  wire           dec_writes_reg,
   input  wire           dec_writes_flags,
   input  wire           dec_halt,
   output reg_id_t       rf_rd_a,
   output reg_id_t       rf_rd_b,
   input  wire data_t    rf_data_a,
   input  wire data_t    rf_data_b,
   output logic          res_valid,
   output reg_id_t       res_dst,
   output data_t         res_data,
   output logic          res_writes_reg,
   output data_t         res_flags,
   output logic          res_writes_flags,
   output logic          res_halt
);

   logic        bypass_a;
   logic        bypass_b;
   data_t       op_a;
   data_t       op_b;
   data_t       result;
   data_t       flags;
   logic [32:0] wide;
   logic        cf;
   logic        of;

   assign rf_rd_a = dec_src_a;
   assign rf_rd_b = dec_src_b;

   // Result register still holds a write the register file has not seen
   assign bypass_a = res_valid && res_writes_reg && (res_dst == dec_src_a);
   assign bypass_b = res_valid && res_writes_reg && (res_dst == dec_src_b);

   assign op_a = bypass_a ? res_data : rf_data_a;
   assign op_b = dec_use_imm ? dec_imm : (bypass_b ? res_data : rf_data_b);

   always_comb begin
      wide   = '0;
      result = op_b;
      cf     = 1'b0;
      of     = 1'b0;
      case (dec_alu_op)
         alu_add: begin
            wide   = {1'b0, op_a} + {1'b0, op_b};
            result = wide[31:0];
            cf     = wide[32];
            of     = (op_a[31] == op_b[31]) && (result[31] != op_a[31]);
         end
         alu_sub: begin
            // Bit 32 of the difference is the borrow
            wide   = {1'b0, op_a} - {1'b0, op_b};
            result = wide[31:0];
            cf     = wide[32];
            of     = (op_a[31] != op_b[31]) && (result[31] != op_a[31]);
         end
         alu_and: result = op_a & op_b;
         alu_or:  result = op_a | op_b;
         alu_xor: result = op_a ^ op_b;
         default: result = op_b;
      endcase
   end

   // Only the four tracked flag bits are carried
   always_comb begin
      flags         = '0;
      flags[cf_bit] = cf;
      flags[zf_bit] = (result == '0);
      flags[sf_bit] = result[31];
      flags[of_bit] = of;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= dec_valid;
      end
   end

   always_ff @(posedge clk) begin
      res_dst          <= dec_dst;
      res_data         <= result;
      res_writes_reg   <= dec_writes_reg;
      res_flags        <= flags;
      res_writes_flags <= dec_writes_flags;
      res_halt         <= dec_halt;
   end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
   import x86_core_pkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire           instr_valid,
   input  wire instr_t   instr,
   output logic          instr_ready,
   input  wire           halted,
   output logic          dec_valid,
   output alu_op_t       dec_alu_op,
   output reg_id_t       dec_dst,
   output reg_id_t       dec_src_a,
   output reg_id_t       dec_src_b,
   output logic          dec_use_imm,
   output data_t         dec_imm,
   output logic          dec_writes_reg,
   output logic          dec_writes_flags,
   output logic          dec_halt
);

   logic    accept;
   logic    halt_seen;
   logic    in_valid;
   instr_t  in_instr;
   opcode_t opcode;
   logic [7:0] modrm;

   alu_op_t alu_op;
   logic    use_imm;
   logic    writes_reg;
   logic    writes_flags;
   logic    is_halt;

   // Only a HLT closes the input, and only reset opens it again
   assign instr_ready = ~halt_seen;
   assign accept      = instr_valid & instr_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         in_valid  <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         in_valid <= accept;
         if ((accept && (instr[47:40] == op_hlt)) || halted) begin
            halt_seen <= 1'b1;
         end
      end
   end

   // Captured instruction word
   always_ff @(posedge clk) begin
      if (accept) begin
         in_instr <= instr;
      end
   end

   assign opcode = opcode_t'(in_instr[47:40]);
   assign modrm  = in_instr[39:32];

   always_comb begin
      alu_op       = alu_add;
      use_imm      = 1'b0;
      writes_reg   = 1'b0;
      writes_flags = 1'b0;
      is_halt      = 1'b0;
      case (opcode)
         op_add, op_or, op_and, op_sub, op_xor: begin
            writes_reg   = 1'b1;
            writes_flags = 1'b1;
            case (opcode)
               op_or:   alu_op = alu_or;
               op_and:  alu_op = alu_and;
               op_sub:  alu_op = alu_sub;
               op_xor:  alu_op = alu_xor;
               default: alu_op = alu_add;
            endcase
         end
         op_mov: begin
            alu_op     = alu_pass_b;
            writes_reg = 1'b1;
         end
         op_mov_imm: begin
            alu_op     = alu_pass_b;
            use_imm    = 1'b1;
            writes_reg = 1'b1;
         end
         op_hlt: is_halt = 1'b1;
         // Anything else retires without side effects
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= in_valid;
      end
   end

   // rm is destination and first source, reg the second; mod is ignored
   always_ff @(posedge clk) begin
      dec_alu_op       <= alu_op;
      dec_dst          <= modrm[2:0];
      dec_src_a        <= modrm[2:0];
      dec_src_b        <= modrm[5:3];
      dec_use_imm      <= use_imm;
      dec_imm          <= in_instr[31:0];
      dec_writes_reg   <= writes_reg;
      dec_writes_flags <= writes_flags;
      dec_halt         <= is_halt;
   end

endmodule

`default_nettype wire

/* x86_core_pkg.sv */
`default_nettype none

package x86_core_pkg;

   // Opcode bytes of the supported subset
   typedef enum logic [7:0] {
      op_add     = 8'h01,
      op_or      = 8'h09,
      op_and     = 8'h21,
      op_sub     = 8'h29,
      op_xor     = 8'h31,
      op_mov     = 8'h89,
      op_mov_imm = 8'hB8,
      op_hlt     = 8'hF4
   } opcode_t;

   // ALU operations selected in decode
   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_pass_b
   } alu_op_t;

   typedef logic [31:0] data_t;
   typedef logic [2:0]  reg_id_t;

   // Opcode in 47..40, ModRM in 39..32, immediate in 31..0
   typedef logic [47:0] instr_t;

   localparam int num_gprs = 8;

   // EFLAGS bit positions
   localparam int cf_bit = 0;
   localparam int zf_bit = 6;
   localparam int sf_bit = 7;
   localparam int of_bit = 11;

   // Bit 1 of EFLAGS always reads as one
   localparam data_t eflags_reset = 32'h0000_0002;

endpackage

`default_nettype wire
